// ==== Bender.yml ====
package:
  name: ccip_lite_afu

sources:
  # RTL, package first
  - verilog/ccip_lite_pkg.sv
  - verilog/countdown_timer.sv
  - verilog/csr_regs.sv
  - verilog/mmio_ctrl_fsm.sv
  - verilog/afu_top.sv

  # Testbench, table header lives in sim
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_afu_top.sv

// ==== sim/tb_afu_table.svh ====
`ifndef TB_AFU_TABLE_SVH
`define TB_AFU_TABLE_SVH

// Row kinds
typedef enum logic [1:0] {
   op_rd      = 2'd0,   // Read and wait for the response
   op_wr      = 2'd1,
   op_idle    = 2'd2,   // data holds the cycle count
   op_rd_pair = 2'd3    // Read plus a second read data cycles later
} t_op;

// One step of stimulus with its expected read value
typedef struct packed {
   t_op        op;
   t_mmio_addr addr;
   t_mmio_data data;       // Write data or idle cycles or pair gap
   t_mmio_data expected;   // Read data the host should see
   logic       check;      // Compare read data
   logic [3:0] test_id;
} t_row;

t_row rows[$];

function automatic string test_name(input int id);
   case (id)
      1:       return "identity and unmapped";
      2:       return "scratch readback";
      3:       return "tid and latency";
      4:       return "busy read drops";
      5:       return "countdown timer";
      6:       return "reset values";
      default: return "unknown";
   endcase
endfunction

task automatic push_row(input t_op op, input t_mmio_addr addr, input t_mmio_data data,
                        input t_mmio_data expected, input logic check, input logic [3:0] id);
   t_row r;
   r.op       = op;
   r.addr     = addr;
   r.data     = data;
   r.expected = expected;
   r.check    = check;
   r.test_id  = id;
   rows.push_back(r);
endtask

// Expected values follow the CSR map and timer rules
task automatic build_table();
   t_mmio_data val_a;
   t_mmio_data val_b;
   t_mmio_data val_c;
   t_mmio_data val_d;
   t_mmio_data junk;
   val_a = rand64();
   val_b = rand64();
   val_c = rand64();
   val_d = rand64();
   junk  = rand64();
   // Values straight out of reset with the timer expired as after a zero load
   push_row(op_rd, csr_scratch0, '0, '0, 1'b1, 4'd6);
   push_row(op_rd, csr_scratch1, '0, '0, 1'b1, 4'd6);
   push_row(op_rd, csr_drop_count, '0, '0, 1'b1, 4'd6);
   push_row(op_rd, csr_timer_status, '0, 64'd1, 1'b1, 4'd6);
   push_row(op_rd, csr_timer_load, '0, '0, 1'b1, 4'd6);
   // Identity registers ignore writes
   push_row(op_rd, csr_afu_dfh, '0, afu_dfh_value, 1'b1, 4'd1);
   push_row(op_rd, csr_afu_id_l, '0, afu_id_lo, 1'b1, 4'd1);
   push_row(op_rd, csr_afu_id_h, '0, afu_id_hi, 1'b1, 4'd1);
   push_row(op_wr, csr_afu_id_l, junk, '0, 1'b0, 4'd1);
   push_row(op_rd, csr_afu_id_l, '0, afu_id_lo, 1'b1, 4'd1);
   push_row(op_wr, csr_afu_dfh, ~junk, '0, 1'b0, 4'd1);
   push_row(op_rd, csr_afu_dfh, '0, afu_dfh_value, 1'b1, 4'd1);
   push_row(op_rd, 16'h0030, '0, '0, 1'b1, 4'd1);       // Unmapped
   push_row(op_wr, 16'h0030, junk, '0, 1'b0, 4'd1);
   push_row(op_rd, 16'h0030, '0, '0, 1'b1, 4'd1);
   push_row(op_rd, 16'h0011, '0, '0, 1'b1, 4'd1);       // Odd word between scratches
   // Reads follow writes in the very next cycle
   push_row(op_wr, csr_scratch0, val_a, '0, 1'b0, 4'd2);
   push_row(op_rd, csr_scratch0, '0, val_a, 1'b1, 4'd2);
   push_row(op_wr, csr_scratch1, val_b, '0, 1'b0, 4'd2);
   push_row(op_rd, csr_scratch1, '0, val_b, 1'b1, 4'd2);
   push_row(op_rd, csr_scratch0, '0, val_a, 1'b1, 4'd2);
   push_row(op_wr, csr_scratch0, val_c, '0, 1'b0, 4'd2);
   push_row(op_idle, '0, 64'd2, '0, 1'b0, 4'd2);
   push_row(op_rd, csr_scratch0, '0, val_c, 1'b1, 4'd2);
   // A lone write stays silent and every read echoes its tid
   push_row(op_wr, csr_scratch1, val_d, '0, 1'b0, 4'd3);
   push_row(op_idle, '0, 64'd6, '0, 1'b0, 4'd3);
   push_row(op_rd, csr_scratch1, '0, val_d, 1'b1, 4'd3);
   push_row(op_rd, csr_scratch0, '0, val_c, 1'b1, 4'd3);
   push_row(op_rd, csr_afu_id_h, '0, afu_id_hi, 1'b1, 4'd3);
   push_row(op_rd, csr_timer_status, '0, 64'd1, 1'b1, 4'd3);
   // Second read lands in access and then in resp
   push_row(op_rd_pair, csr_afu_dfh, 64'd1, afu_dfh_value, 1'b1, 4'd4);
   push_row(op_rd_pair, csr_afu_dfh, 64'd2, afu_dfh_value, 1'b1, 4'd4);
   push_row(op_rd, csr_drop_count, '0, 64'd2, 1'b1, 4'd4);
   // Timer load then expiry after the count and a zero load
   push_row(op_wr, csr_timer_load, 64'd20, '0, 1'b0, 4'd5);
   push_row(op_rd, csr_timer_status, '0, '0, 1'b1, 4'd5);
   push_row(op_idle, '0, 64'd30, '0, 1'b0, 4'd5);
   push_row(op_rd, csr_timer_status, '0, 64'd1, 1'b1, 4'd5);
   push_row(op_rd, csr_timer_load, '0, 64'd20, 1'b1, 4'd5);
   push_row(op_wr, csr_timer_load, 64'd1000, '0, 1'b0, 4'd5);
   push_row(op_rd, csr_timer_status, '0, '0, 1'b1, 4'd5);
   push_row(op_wr, csr_timer_load, '0, '0, 1'b0, 4'd5);
   push_row(op_rd, csr_timer_status, '0, 64'd1, 1'b1, 4'd5);
   push_row(op_rd, csr_timer_load, '0, '0, 1'b1, 4'd5);
endtask

`endif

// ==== sim/tb_afu_top.sv ====
`timescale 1ns/1ps

// Table driven testbench for the AFU MMIO path
module tb_afu_top;

   import ccip_lite_pkg::*;

   localparam int clk_half     = 2;     // 4 ns period
   localparam int reset_cycles = 16;
   localparam int rsp_limit    = 8;     // Cycles allowed for a response
   localparam int wd_margin    = 200;

   logic        pClk;
   logic        rst;
   t_if_ccip_rx rx;   // Host requests
   t_if_ccip_tx tx;   // AFU responses

   logic [31:0] rng_state;
   int          rsp_count;      // Responses seen on the bus
   int          rsp_expected;   // Responses the host should get
   int          pass_total;
   int          fail_total;
   int          test_checks;    // Checks in current test
   int          test_fails;
   bit          table_ready;

   // xorshift32
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic t_mmio_data rand64();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi, lo};
   endfunction

   `include "tb_afu_table.svh"

   afu_top i_afu_top (
      .pClk          (pClk),
      .rst           (rst ),
      .pck_cp2af_sRx (rx  ),
      .pck_af2cp_sTx (tx  )
   );

   initial begin
      pClk = 1'b0;
      forever #clk_half pClk = ~pClk;
   end

   // Every response counted mid-cycle
   always @(negedge pClk) begin
      if (tx.mmio_rsp_valid === 1'b1) rsp_count++;
   end

   task automatic count_pass();
      pass_total++;
      test_checks++;
   endtask

   task automatic count_fail();
      fail_total++;
      test_checks++;
      test_fails++;
   endtask

   task automatic send_write(input t_mmio_addr addr, input t_mmio_data data);
      t_if_ccip_rx req;
      req         = '0;
      req.mmio_wr = 1'b1;
      req.addr    = addr;
      req.data    = data;
      rx <= req;
      @(posedge pClk);   // Write taken here
      rx <= '0;
   endtask

   // Read plus an optional second read gap cycles later that must be dropped
   task automatic send_read(input t_mmio_addr addr, input t_mmio_data exp,
                            input logic check, input int gap);
      t_if_ccip_rx req;
      t_mmio_tid   tid;
      logic [31:0] r;
      int          edges;
      bit          got;
      r           = next_rand();
      tid         = r[mmio_tid_w-1:0];
      req         = '0;
      req.mmio_rd = 1'b1;
      req.addr    = addr;
      req.tid     = tid;
      rsp_expected++;
      rx <= req;
      @(posedge pClk);   // Read accepted at edge N
      rx <= '0;
      edges = 0;
      got   = 1'b0;
      if (gap > 0) begin
         repeat (gap - 1) begin
            @(posedge pClk);
            edges++;
         end
         req.tid = ~tid;
         rx <= req;
         @(posedge pClk);   // FSM busy here
         edges++;
         rx <= '0;
      end
      while (!got && edges <= rsp_limit) begin
         @(negedge pClk);
         if (tx.mmio_rsp_valid === 1'b1) begin
            got = 1'b1;
         end else begin
            @(posedge pClk);
            edges++;
         end
      end
      assert (got)
      else begin
         $display("No read response within %0d cycles for addr %h tid %h",
                  rsp_limit, addr, tid);
         count_fail();
      end
      if (got) begin
         assert (edges == 2) count_pass();
         else begin
            $display("ERROR %0t: addr %h expected latency 2 got %0d", $time, addr, edges);
            count_fail();
         end
         assert (tx.tid == tid) count_pass();
         else begin
            $display("ERROR %0t: addr %h expected tid %h got %h", $time, addr, tid, tx.tid);
            count_fail();
         end
         if (check) begin
            assert (tx.data == exp) count_pass();
            else begin
               $display("ERROR %0t: addr %h expected %h got %h", $time, addr, exp, tx.data);
               count_fail();
            end
         end
      end
      if (gap > 0) repeat (4) @(posedge pClk);   // Late answer to the dropped read
      @(posedge pClk);
   endtask

   // No extra or missing responses so far
   task automatic check_rsp_count();
      assert (rsp_count == rsp_expected) count_pass();
      else begin
         $display("ERROR %0t: expected %0d responses got %0d", $time, rsp_expected, rsp_count);
         count_fail();
      end
   endtask

   task automatic finish_test(input int id);
      $display("Test %0d %s: %s, %0d checks, %0d failed", id, test_name(id),
               (test_fails == 0) ? "passed" : "failed", test_checks, test_fails);
      test_checks = 0;
      test_fails  = 0;
   endtask

   initial begin : run
      t_row row;
      int   cur_test;
      rst          = 1'b1;
      rx           = '0;
      rng_state    = 32'd34;
      rsp_count    = 0;
      rsp_expected = 0;
      pass_total   = 0;
      fail_total   = 0;
      test_checks  = 0;
      test_fails   = 0;
      build_table();
      table_ready = 1'b1;
      repeat (reset_cycles) @(posedge pClk);
      rst <= 1'b0;
      @(posedge pClk);
      cur_test = rows[0].test_id;
      foreach (rows[i]) begin
         row = rows[i];
         if (row.test_id != cur_test) begin
            finish_test(cur_test);
            cur_test = row.test_id;
         end
         case (row.op)
            op_wr:      send_write(row.addr, row.data);
            op_idle:    repeat (int'(row.data)) @(posedge pClk);
            op_rd:      send_read(row.addr, row.expected, row.check, 0);
            op_rd_pair: send_read(row.addr, row.expected, row.check, int'(row.data));
            default:    @(posedge pClk);
         endcase
         check_rsp_count();
      end
      finish_test(cur_test);
      $display("Checks passed %0d, failed %0d", pass_total, fail_total);
      if (fail_total == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Budget of 8 cycles a row beyond reset
   initial begin : watchdog
      int limit;
      wait (table_ready);
      limit = rows.size() * 8 + reset_cycles + wd_margin;
      repeat (limit) @(posedge pClk);
      $display("Watchdog expired after %0d cycles, the table did not complete", limit);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== verilog/afu_top.sv ====
`timescale 1ns/1ps

// AFU top level
// Host structs in and out, FSM plus CSR file plus timer inside
module afu_top (
   input  logic                       pClk,
   input  logic                       rst,
   input  ccip_lite_pkg::t_if_ccip_rx pck_cp2af_sRx,
   output ccip_lite_pkg::t_if_ccip_tx pck_af2cp_sTx
);

   import ccip_lite_pkg::*;

   t_csr_rd_req csr_rd;        // FSM read request
   t_csr_wr_req csr_wr;        // Host writes
   t_mmio_data  rd_data;       // Registered CSR data
   logic        drop;          // Read lost while busy
   logic        load_strobe;   // Timer start
   logic [timer_w-1:0] load_value;
   logic        expired;

   // Request sequencing and response
   mmio_ctrl_fsm i_mmio_ctrl_fsm (
      .pClk    (pClk         ),
      .rst     (rst          ),
      .rx      (pck_cp2af_sRx),
      .csr_rd  (csr_rd       ),
      .csr_wr  (csr_wr       ),
      .drop    (drop         ),
      .rd_data (rd_data      ),
      .tx      (pck_af2cp_sTx)
   );

   // Register file
   csr_regs i_csr_regs (
      .pClk        (pClk       ),
      .rst         (rst        ),
      .csr_rd      (csr_rd     ),
      .csr_wr      (csr_wr     ),
      .drop        (drop       ),
      .expired     (expired    ),
      .rd_data     (rd_data    ),
      .load_strobe (load_strobe),
      .load_value  (load_value )
   );

   // Software delay timer
   countdown_timer i_countdown_timer (
      .pClk        (pClk       ),
      .rst         (rst        ),
      .load_strobe (load_strobe),
      .load_value  (load_value ),
      .expired     (expired    )
   );

endmodule

// ==== verilog/ccip_lite_pkg.sv ====
package ccip_lite_pkg;

   // MMIO field widths, addresses in 32-bit words
   localparam int mmio_addr_w = 16;
   localparam int mmio_tid_w  = 9;
   localparam int mmio_data_w = 64;

   localparam int timer_w     = 32;   // Countdown timer width
   localparam int drop_cnt_w  = 32;   // Dropped read counter width

   typedef logic [mmio_addr_w-1:0] t_mmio_addr;
   typedef logic [mmio_tid_w-1:0]  t_mmio_tid;
   typedef logic [mmio_data_w-1:0] t_mmio_data;

   // Host to AFU, 91 bits
   typedef struct packed {
      logic       mmio_rd;   // Read strobe, one cycle
      logic       mmio_wr;   // Write strobe, one cycle
      t_mmio_addr addr;
      t_mmio_tid  tid;
      t_mmio_data data;      // Write data
   } t_if_ccip_rx;

   // AFU to host, 74 bits
   typedef struct packed {
      logic       mmio_rsp_valid;   // Response strobe, no back-pressure
      t_mmio_tid  tid;              // Echo of request tid
      t_mmio_data data;
   } t_if_ccip_tx;

   // Read request from FSM into register file
   typedef struct packed {
      logic       rd;
      t_mmio_addr addr;
   } t_csr_rd_req;

   // Write path into register file
   typedef struct packed {
      logic       wr;
      t_mmio_addr addr;
      t_mmio_data data;
   } t_csr_wr_req;

   // CSR map, word units, every register is 64 bits
   localparam t_mmio_addr csr_afu_dfh      = 16'h0000;   // RO
   localparam t_mmio_addr csr_afu_id_l     = 16'h0002;   // RO
   localparam t_mmio_addr csr_afu_id_h     = 16'h0004;   // RO
   localparam t_mmio_addr csr_scratch0     = 16'h0010;   // RW
   localparam t_mmio_addr csr_scratch1     = 16'h0012;   // RW
   localparam t_mmio_addr csr_timer_load   = 16'h0020;   // RW, write starts timer
   localparam t_mmio_addr csr_timer_status = 16'h0022;   // RO, bit 0 expired
   localparam t_mmio_addr csr_drop_count   = 16'h0024;   // RO, saturating

   // Device feature header
   // Type AFU in [63:60], end of list in bit 40, feature id 1
   localparam t_mmio_data afu_dfh_value = 64'h1000_0100_0000_0001;

   // AFU identity, 128-bit id split in two halves
   localparam t_mmio_data afu_id_lo     = 64'h9d73_e2b4_5c61_0a8f;
   localparam t_mmio_data afu_id_hi     = 64'h4b2c_7a10_e6f3_58d2;

   // MMIO control FSM
   //   st_idle    waiting for a read
   //   st_access  read request presented to CSR file
   //   st_resp    CSR data registered, response formed
   typedef enum logic [1:0] {
      st_idle   = 2'd0,
      st_access = 2'd1,
      st_resp   = 2'd2
   } t_ctrl_state;

endpackage

// ==== verilog/countdown_timer.sv ====
`timescale 1ns/1ps

// One-shot down-counter
// Loads on strobe, counts to zero and parks there
// expired high from reaching zero until next load
module countdown_timer (
   input  logic                              pClk,
   input  logic                              rst,
   input  logic                              load_strobe,
   input  logic [ccip_lite_pkg::timer_w-1:0] load_value,
   output logic                              expired
);

   import ccip_lite_pkg::*;

   logic [timer_w-1:0] count_q;
   logic               at_last;   // One cycle left

   assign at_last = (count_q == timer_w'(1));

   always_ff @(posedge pClk) begin
      if (rst) begin
         count_q <= '0;
         expired <= 1'b1;   // Same as a zero load
      end else if (load_strobe) begin
         count_q <= load_value;
         expired <= (load_value == '0);   // Zero load expires at once
      end else if (count_q != '0) begin
         count_q <= count_q - 1'b1;
         if (at_last) expired <= 1'b1;
      end
   end

endmodule

// ==== verilog/csr_regs.sv ====
`timescale 1ns/1ps

// AFU CSR file
// Identity constants, scratch pair, timer load and status, drop count
module csr_regs (
   input  logic                                  pClk,
   input  logic                                  rst,
   input  ccip_lite_pkg::t_csr_rd_req            csr_rd,
   input  ccip_lite_pkg::t_csr_wr_req            csr_wr,
   input  logic                                  drop,
   input  logic                                  expired,
   output logic [ccip_lite_pkg::mmio_data_w-1:0] rd_data,
   output logic                                  load_strobe,
   output logic [ccip_lite_pkg::timer_w-1:0]     load_value
);

   import ccip_lite_pkg::*;

   t_mmio_data scratch0_q;
   t_mmio_data scratch1_q;
   logic [timer_w-1:0]    timer_load_q;   // Last value loaded
   logic [drop_cnt_w-1:0] drop_cnt_q;

   // Write decode
   logic wr_scratch0;
   logic wr_scratch1;
   logic wr_timer;

   t_mmio_data rd_mux;   // Read value before the output register

   assign wr_scratch0 = csr_wr.wr && (csr_wr.addr == csr_scratch0);
   assign wr_scratch1 = csr_wr.wr && (csr_wr.addr == csr_scratch1);
   assign wr_timer    = csr_wr.wr && (csr_wr.addr == csr_timer_load);
   // RO and unmapped writes fall through, nothing decoded

   always_ff @(posedge pClk) begin
      if (rst) begin
         scratch0_q   <= '0;
         scratch1_q   <= '0;
         timer_load_q <= '0;
         load_strobe  <= 1'b0;
      end else begin
         if (wr_scratch0) scratch0_q <= csr_wr.data;
         if (wr_scratch1) scratch1_q <= csr_wr.data;
         if (wr_timer) timer_load_q <= csr_wr.data[timer_w-1:0];   // Upper bits dropped
         load_strobe <= wr_timer;   // Timer loads one edge after write
      end
   end

   // Timer always takes its value from the load register
   assign load_value = timer_load_q;

   // Dropped read counter, sticks at all ones
   always_ff @(posedge pClk) begin
      if (rst) begin
         drop_cnt_q <= '0;
      end else if (drop && (drop_cnt_q != '1)) begin
         drop_cnt_q <= drop_cnt_q + 1'b1;
      end
   end

   // Read select
   always_comb begin
      case (csr_rd.addr)
         csr_afu_dfh:      rd_mux = afu_dfh_value;
         csr_afu_id_l:     rd_mux = afu_id_lo;
         csr_afu_id_h:     rd_mux = afu_id_hi;
         csr_scratch0:     rd_mux = scratch0_q;
         csr_scratch1:     rd_mux = scratch1_q;
         csr_timer_load:   rd_mux = t_mmio_data'(timer_load_q);   // Zero extended
         csr_timer_status: rd_mux = t_mmio_data'(expired);        // Bit 0 only
         csr_drop_count:   rd_mux = t_mmio_data'(drop_cnt_q);
         default:          rd_mux = '0;   // Unmapped reads as zero
      endcase
   end

   // Registered read data, one cycle after request
   always_ff @(posedge pClk) begin
      if (csr_rd.rd) begin
         rd_data <= rd_mux;
      end
   end

endmodule

// ==== verilog/mmio_ctrl_fsm.sv ====
`timescale 1ns/1ps

// Accepts MMIO requests from the host struct
// One read in flight at a time
// Writes go through in any state
module mmio_ctrl_fsm (
   input  logic                                  pClk,
   input  logic                                  rst,
   input  ccip_lite_pkg::t_if_ccip_rx            rx,
   output ccip_lite_pkg::t_csr_rd_req            csr_rd,
   output ccip_lite_pkg::t_csr_wr_req            csr_wr,
   output logic                                  drop,
   input  logic [ccip_lite_pkg::mmio_data_w-1:0] rd_data,
   output ccip_lite_pkg::t_if_ccip_tx            tx
);

   import ccip_lite_pkg::*;

   t_ctrl_state state_q;
   t_ctrl_state state_d;

   logic       rd_accept;   // Read taken in idle
   t_mmio_addr rd_addr_q;   // Address of read in flight
   t_mmio_tid  rd_tid_q;    // Tid of read in flight

   // Response registers
   logic       rsp_valid_q;
   t_mmio_tid  rsp_tid_q;
   t_mmio_data rsp_data_q;

   assign rd_accept = rx.mmio_rd && (state_q == st_idle);

   // Busy reads are lost and counted in the CSR file
   assign drop = rx.mmio_rd && (state_q != st_idle);

   // Next state
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (rx.mmio_rd) state_d = st_access;
         end
         st_access: state_d = st_resp;    // CSR file registers data here
         st_resp:   state_d = st_idle;    // Response goes out this edge
         default:   state_d = st_idle;
      endcase
   end

   always_ff @(posedge pClk) begin
      if (rst) begin
         state_q <= st_idle;
      end else begin
         state_q <= state_d;
      end
   end

   // Capture address and tid of an accepted read
   always_ff @(posedge pClk) begin
      if (rd_accept) begin
         rd_addr_q <= rx.addr;
         rd_tid_q  <= rx.tid;
      end
   end

   // One-cycle read request while in access
   assign csr_rd.rd   = (state_q == st_access);
   assign csr_rd.addr = rd_addr_q;

   // Writes need no sequencing
   assign csr_wr.wr   = rx.mmio_wr;
   assign csr_wr.addr = rx.addr;
   assign csr_wr.data = rx.data;

   // Response strobe follows st_resp by one edge
   always_ff @(posedge pClk) begin
      if (rst) begin
         rsp_valid_q <= 1'b0;
      end else begin
         rsp_valid_q <= (state_q == st_resp);
      end
   end

   // Response payload takes the registered CSR data
   always_ff @(posedge pClk) begin
      if (state_q == st_resp) begin
         rsp_tid_q  <= rd_tid_q;
         rsp_data_q <= rd_data;
      end
   end

   assign tx.mmio_rsp_valid = rsp_valid_q;
   assign tx.tid            = rsp_tid_q;
   assign tx.data           = rsp_data_q;

endmodule

// ==== vlog.f ====
+incdir+sim
verilog/ccip_lite_pkg.sv
verilog/countdown_timer.sv
verilog/csr_regs.sv
verilog/mmio_ctrl_fsm.sv
verilog/afu_top.sv
sim/tb_afu_top.sv
